//--- source/noc_pkg.sv
/* Shared router constants, coordinate and flit structs,
   and the output port enumeration */
package noc_pkg;

  // Five ports: local eject plus four mesh neighbours
  localparam int unsigned NumPorts = 5;

  // Index width for selecting one of the ports
  localparam int unsigned PortIdxWidth = $clog2(NumPorts);

  // 2-bit coordinates give a 4 by 4 mesh
  localparam int unsigned CoordWidth = 2;

  // Payload bits carried by every flit
  localparam int unsigned PayloadWidth = 16;

  // Mesh position, used for destinations and the router's own spot
  typedef struct packed {
    logic [CoordWidth-1:0] x;
    logic [CoordWidth-1:0] y;
  } coord_t;

  // Routing header, present on every flit of a packet
  typedef struct packed {
    coord_t dst;
    // Marks the tail flit, releases the wormhole locks
    logic   last;
  } flit_hdr_t;

  // Complete flit as it moves through buffers and arbiters
  typedef struct packed {
    flit_hdr_t                 hdr;
    logic [PayloadWidth-1:0]   payload;
  } flit_t;

  // Port numbering
  // y decreasing is South, x decreasing is West
  typedef enum logic [2:0] {
    Eject = 3'd0,
    South = 3'd1,
    West  = 3'd2,
    North = 3'd3,
    East  = 3'd4
  } port_e;

endpackage

//--- source/flit_fifo.sv
/* Per-input circular flit buffer with valid/ready on write and read side */
`timescale 1ns/1ps

module flit_fifo
  import noc_pkg::*;
#(
  parameter int unsigned FifoDepth = 2
) (
  input  logic  clk_i,
  input  logic  rst_i,
  // Write side from the router input port
  input  flit_t flit_i,
  input  logic  valid_i,
  output logic  ready_o,
  // Read side towards route selection and arbiters
  output flit_t flit_o,
  output logic  valid_o,
  input  logic  ready_i
);

  // Pointer width never drops below one bit
  localparam int unsigned PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int unsigned CntWidth = $clog2(FifoDepth + 1);

  // Storage, payload only, no reset
  flit_t mem_q [FifoDepth];

  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;

  logic full;
  logic push;
  logic pop;

  assign full    = (count_q == CntWidth'(FifoDepth));
  assign valid_o = (count_q != '0);
  assign flit_o  = mem_q[rd_ptr_q];

  // A full buffer still takes a flit while the head leaves
  assign ready_o = !full || ready_i;

  assign push = valid_i && ready_o;
  assign pop  = valid_o && ready_i;

  // Pointers and occupancy
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        // Wrap at the end of the buffer
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keep the count
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Write port
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= flit_i;
    end
  end

endmodule

//--- source/route_select.sv
/* XY route computation with a wormhole route lock per input */
`timescale 1ns/1ps

module route_select
  import noc_pkg::*;
#(
  parameter bit LockRouting = 1'b1
) (
  input  logic                clk_i,
  input  logic                rst_i,
  // Own position in the mesh
  input  coord_t              xy_id_i,
  // Head flit of the input buffer
  input  flit_t               flit_i,
  input  logic                valid_i,
  input  logic                ready_i,
  // One-hot output port choice
  output logic [NumPorts-1:0] route_sel_o
);

  port_e               route_id;
  logic [NumPorts-1:0] route_sel;
  coord_t              dst;

  assign dst = flit_i.hdr.dst;

  // Dimension ordered routing
  // X offset is resolved first, Y only once X matches
  always_comb begin
    route_id = East;
    if (dst == xy_id_i) begin
      route_id = Eject;
    end else if (dst.x == xy_id_i.x) begin
      if (dst.y < xy_id_i.y) begin
        route_id = South;
      end else begin
        route_id = North;
      end
    end else begin
      if (dst.x < xy_id_i.x) begin
        route_id = West;
      end else begin
        route_id = East;
      end
    end
  end

  // One-hot encoding of the chosen port
  always_comb begin
    route_sel = '0;
    route_sel[route_id] = 1'b1;
  end

  if (LockRouting) begin : gen_lock
    logic                locked_q;
    logic [NumPorts-1:0] route_sel_q;
    logic                xfer;

    // Flit leaves the input buffer
    assign xfer = valid_i && ready_i;

    // Body and tail flits follow the route of the head flit
    assign route_sel_o = locked_q ? route_sel_q : route_sel;

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        locked_q    <= 1'b0;
        route_sel_q <= '0;
      end else if (xfer) begin
        // Tail flit releases the lock
        locked_q <= !flit_i.hdr.last;
        // Capture the route only from the head flit
        if (!locked_q) begin
          route_sel_q <= route_sel;
        end
      end
    end
  end else begin : gen_no_lock
    // Each flit routed on its own header
    assign route_sel_o = route_sel;
  end

endmodule

//--- source/output_arbiter.sv
/* Round-robin output arbiter with packet lock and output flit multiplexer */
`timescale 1ns/1ps

module output_arbiter
  import noc_pkg::*;
#(
  parameter bit LockRouting = 1'b1
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  // Requests and head flits from all inputs
  input  logic        [NumPorts-1:0] req_i,
  input  flit_t       [NumPorts-1:0] flits_i,
  output logic        [NumPorts-1:0] gnt_o,
  // Output port
  output flit_t                      flit_o,
  output logic                       valid_o,
  input  logic                       ready_i
);

  // First input to consider in the next search
  logic [PortIdxWidth-1:0] next_q;
  // Input holding the output during a packet
  logic [PortIdxWidth-1:0] lock_idx_q;
  logic                    locked_q;

  logic [PortIdxWidth-1:0] sel;
  logic [PortIdxWidth-1:0] sel_inc;
  logic                    found;
  logic                    xfer;

  // Round-robin search starting at next_q
  always_comb begin
    int unsigned idx;
    found = 1'b0;
    sel   = next_q;
    for (int unsigned k = 0; k < NumPorts; k++) begin
      idx = int'(next_q) + k;
      if (idx >= NumPorts) begin
        idx = idx - NumPorts;
      end
      if (!found && req_i[idx]) begin
        found = 1'b1;
        sel   = PortIdxWidth'(idx);
      end
    end
    // Locked packet overrides the search
    if (locked_q) begin
      sel   = lock_idx_q;
      found = req_i[lock_idx_q];
    end
  end

  // Grant and output do not depend on ready
  always_comb begin
    gnt_o = '0;
    if (found) begin
      gnt_o[sel] = 1'b1;
    end
  end

  assign valid_o = found;
  assign flit_o  = flits_i[sel];
  assign xfer    = valid_o && ready_i;

  // Input after the granted one, with wrap
  assign sel_inc = (sel == PortIdxWidth'(NumPorts - 1)) ? '0 : sel + 1'b1;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      next_q     <= '0;
      lock_idx_q <= '0;
      locked_q   <= 1'b0;
    end else if (xfer) begin
      if (flit_o.hdr.last || !LockRouting) begin
        // End of packet, pass priority on
        locked_q <= 1'b0;
        next_q   <= sel_inc;
      end else begin
        // Hold the output for the rest of the packet
        locked_q   <= 1'b1;
        lock_idx_q <= sel;
      end
    end
  end

endmodule

//--- source/mesh_router.sv
/* Five-port mesh router top: input buffers, XY route selectors,
   output arbiters and the request and ready wiring between them */
`timescale 1ns/1ps

module mesh_router
  import noc_pkg::*;
#(
  parameter int unsigned FifoDepth   = 2,
  parameter bit          LockRouting = 1'b1
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // Router position
  input  coord_t                xy_id_i,
  // Input ports
  input  flit_t [NumPorts-1:0]  in_flit_i,
  input  logic  [NumPorts-1:0]  in_valid_i,
  output logic  [NumPorts-1:0]  in_ready_o,
  // Output ports
  output flit_t [NumPorts-1:0]  out_flit_o,
  output logic  [NumPorts-1:0]  out_valid_o,
  input  logic  [NumPorts-1:0]  out_ready_i
);

  // Buffer heads, indexed by input
  flit_t [NumPorts-1:0] fifo_flit;
  logic  [NumPorts-1:0] fifo_valid;
  logic  [NumPorts-1:0] fifo_ready;

  // Route choice per input, indexed [input][output]
  logic [NumPorts-1:0][NumPorts-1:0] route_sel;
  // Requests and grants per output, indexed [output][input]
  logic [NumPorts-1:0][NumPorts-1:0] req;
  logic [NumPorts-1:0][NumPorts-1:0] gnt;

  // Transpose route choices into requests
  // and collect the grants back into buffer readies
  always_comb begin
    fifo_ready = '0;
    for (int o = 0; o < NumPorts; o++) begin
      for (int i = 0; i < NumPorts; i++) begin
        req[o][i] = fifo_valid[i] && route_sel[i][o];
        // A grant only pops the buffer once the output takes the flit
        fifo_ready[i] = fifo_ready[i] | (gnt[o][i] & out_ready_i[o]);
      end
    end
  end

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port
    flit_fifo #(
      .FifoDepth ( FifoDepth )
    ) flit_fifo_inst (
      .clk_i   ( clk_i         ),
      .rst_i   ( rst_i         ),
      .flit_i  ( in_flit_i[p]  ),
      .valid_i ( in_valid_i[p] ),
      .ready_o ( in_ready_o[p] ),
      .flit_o  ( fifo_flit[p]  ),
      .valid_o ( fifo_valid[p] ),
      .ready_i ( fifo_ready[p] )
    );

    route_select #(
      .LockRouting ( LockRouting )
    ) route_select_inst (
      .clk_i       ( clk_i         ),
      .rst_i       ( rst_i         ),
      .xy_id_i     ( xy_id_i       ),
      .flit_i      ( fifo_flit[p]  ),
      .valid_i     ( fifo_valid[p] ),
      .ready_i     ( fifo_ready[p] ),
      .route_sel_o ( route_sel[p]  )
    );

    // Arbiter for output p sees every buffer head
    output_arbiter #(
      .LockRouting ( LockRouting )
    ) output_arbiter_inst (
      .clk_i   ( clk_i          ),
      .rst_i   ( rst_i          ),
      .req_i   ( req[p]         ),
      .flits_i ( fifo_flit      ),
      .gnt_o   ( gnt[p]         ),
      .flit_o  ( out_flit_o[p]  ),
      .valid_o ( out_valid_o[p] ),
      .ready_i ( out_ready_i[p] )
    );
  end

endmodule

//--- test/router_checks.svh
/* Typed compare tasks, flit and coordinate builders,
   and the XY expected-port model */
`ifndef ROUTER_CHECKS_SVH
`define ROUTER_CHECKS_SVH

// Flit contents, whole struct shown in hex
task automatic check_flit(input string name, input flit_t exp, input flit_t act);
  if (exp !== act) begin
    $display("MISMATCH %s: expected %h, got %h", name, exp, act);
    err_count++;
  end
endtask

// Output port a flit left on
task automatic check_port(input port_e exp, input port_e act);
  if (exp !== act) begin
    $display("MISMATCH output port: expected %h, got %h", exp, act);
    err_count++;
  end
endtask

// Per-port status vectors such as valid and ready
task automatic check_bits(input string name, input logic [NumPorts-1:0] exp,
                          input logic [NumPorts-1:0] act);
  if (exp !== act) begin
    $display("MISMATCH %s: expected %h, got %h", name, exp, act);
    err_count++;
  end
endtask

// Number of flits seen on an output
task automatic check_count(input string name, input int exp, input int act);
  if (exp != act) begin
    $display("MISMATCH %s: expected %h, got %h", name, exp, act);
    err_count++;
  end
endtask

function automatic coord_t make_coord(input int x, input int y);
  coord_t c;
  c.x = CoordWidth'(x);
  c.y = CoordWidth'(y);
  return c;
endfunction

function automatic flit_t make_flit(input coord_t dst, input logic last,
                                    input logic [PayloadWidth-1:0] payload);
  flit_t f;
  f.hdr.dst  = dst;
  f.hdr.last = last;
  f.payload  = payload;
  return f;
endfunction

// XY rule from signed offsets, X settled before Y
function automatic port_e expected_port(input coord_t own, input coord_t dst);
  int dx;
  int dy;
  dx = int'(dst.x) - int'(own.x);
  dy = int'(dst.y) - int'(own.y);
  if (dx > 0) return East;
  if (dx < 0) return West;
  if (dy > 0) return North;
  if (dy < 0) return South;
  return Eject;
endfunction

`endif

//--- test/router_tb.sv
/* Router testbench with clock, reset, DUT, directed tests,
   traffic driver with output collection, timeout and summary */
`timescale 1ns/1ps

module router_tb
  import noc_pkg::*;
();

  // All tests together need fewer than 100 cycles
  localparam int MaxCycles = 2000;

  logic                 clk_i;
  logic                 rst_i;
  coord_t               xy_id_i;
  flit_t [NumPorts-1:0] in_flit_i;
  logic  [NumPorts-1:0] in_valid_i;
  logic  [NumPorts-1:0] in_ready_o;
  flit_t [NumPorts-1:0] out_flit_o;
  logic  [NumPorts-1:0] out_valid_o;
  logic  [NumPorts-1:0] out_ready_i;

  int     err_count   = 0;
  int     cycle_count = 0;
  integer seed        = 13;
  bit     ready_dropped;

  // Flits still to send per input and flits received and expected per output
  flit_t tx_q [NumPorts][$];
  flit_t rx_q [NumPorts][$];
  flit_t exp_q[NumPorts][$];

  `include "router_checks.svh"

  mesh_router #(
    .FifoDepth   ( 2    ),
    .LockRouting ( 1'b1 )
  ) mesh_router_inst (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .xy_id_i     ( xy_id_i     ),
    .in_flit_i   ( in_flit_i   ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .out_flit_o  ( out_flit_o  ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic finish_run();
    $display("Run complete with %0d errors", err_count);
    if (err_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  task automatic clear_queues();
    for (int p = 0; p < NumPorts; p++) begin
      tx_q[p].delete();
      rx_q[p].delete();
      exp_q[p].delete();
    end
  endtask

  // Drives inputs each falling edge until all queues and outputs drain
  // Outputs are held not ready for the first stall_cycles cycles
  task automatic run_traffic(input int stall_cycles);
    logic [NumPorts-1:0] held;
    flit_t               held_flit[NumPorts];
    bit                  done;
    held          = '0;
    done          = 1'b0;
    ready_dropped = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      for (int p = 0; p < NumPorts; p++) begin
        in_valid_i[p] = (tx_q[p].size() != 0);
        in_flit_i[p]  = in_valid_i[p] ? tx_q[p][0] : '0;
      end
      out_ready_i = (stall_cycles > 0) ? {NumPorts{1'b0}} : {NumPorts{1'b1}};
      if (stall_cycles > 0) begin
        stall_cycles--;
      end
      // Settled values decide the transfers at the next rising edge
      #2;
      for (int p = 0; p < NumPorts; p++) begin
        // A stalled output must keep valid and its flit
        if (held[p] && !out_valid_o[p]) begin
          $display("Output %0d dropped valid before its flit was taken", p);
          err_count++;
        end else if (held[p]) begin
          check_flit($sformatf("out_flit_o[%0d]", p), held_flit[p], out_flit_o[p]);
        end
        held[p]      = out_valid_o[p] && !out_ready_i[p];
        held_flit[p] = out_flit_o[p];
        if (in_valid_i[p] && !in_ready_o[p]) begin
          ready_dropped = 1'b1;
        end
        if (in_valid_i[p] && in_ready_o[p]) begin
          void'(tx_q[p].pop_front());
        end
        if (out_valid_o[p] && out_ready_i[p]) begin
          rx_q[p].push_back(out_flit_o[p]);
        end
      end
      done = (in_valid_i == '0) && (out_valid_o == '0);
    end
  endtask

  // Every output against its expected flit sequence
  task automatic compare_outputs();
    for (int p = 0; p < NumPorts; p++) begin
      check_count($sformatf("flit count on output %0d", p), exp_q[p].size(), rx_q[p].size());
      for (int i = 0; i < exp_q[p].size() && i < rx_q[p].size(); i++) begin
        check_flit($sformatf("out_flit_o[%0d]", p), exp_q[p][i], rx_q[p][i]);
      end
    end
  endtask

  task automatic idle_after_reset();
    #2;
    check_bits("out_valid_o", {NumPorts{1'b0}}, out_valid_o);
    check_bits("in_ready_o", {NumPorts{1'b1}}, in_ready_o);
  endtask

  // One single-flit packet from East per mesh node
  task automatic xy_all_destinations();
    coord_t dst;
    flit_t  f;
    int     arrived;
    for (int x = 0; x < 4; x++) begin
      for (int y = 0; y < 4; y++) begin
        clear_queues();
        dst = make_coord(x, y);
        f   = make_flit(dst, 1'b1, PayloadWidth'($random(seed)));
        tx_q[East].push_back(f);
        run_traffic(0);
        arrived = 0;
        for (int p = 0; p < NumPorts; p++) begin
          if (rx_q[p].size() != 0) begin
            arrived += rx_q[p].size();
            check_port(expected_port(xy_id_i, dst), port_e'(p));
            check_flit($sformatf("out_flit_o[%0d]", p), f, rx_q[p][0]);
          end
        end
        check_count("flits delivered", 1, arrived);
      end
    end
  endtask

  // Body flits carry other destinations while the head decides the route
  task automatic packet_route_lock();
    coord_t dsts[4];
    flit_t  f;
    clear_queues();
    dsts[0] = make_coord(3, 1);
    dsts[1] = make_coord(0, 0);
    dsts[2] = make_coord(1, 3);
    dsts[3] = make_coord(1, 1);
    for (int i = 0; i < 4; i++) begin
      f = make_flit(dsts[i], i == 3, PayloadWidth'($random(seed)));
      tx_q[West].push_back(f);
      exp_q[East].push_back(f);
    end
    run_traffic(0);
    compare_outputs();
  endtask

  // North and South inputs both send a packet to Eject
  task automatic two_input_contention();
    flit_t pkt_a[3];
    flit_t pkt_b[3];
    clear_queues();
    for (int i = 0; i < 3; i++) begin
      pkt_a[i] = make_flit(xy_id_i, i == 2, PayloadWidth'($random(seed)));
      pkt_b[i] = make_flit(xy_id_i, i == 2, PayloadWidth'($random(seed)));
      tx_q[North].push_back(pkt_a[i]);
      tx_q[South].push_back(pkt_b[i]);
    end
    run_traffic(0);
    // Eject last served the East input
    // Search wraps to input 0 and meets South before North
    for (int i = 0; i < 3; i++) begin
      exp_q[Eject].push_back(pkt_b[i]);
    end
    for (int i = 0; i < 3; i++) begin
      exp_q[Eject].push_back(pkt_a[i]);
    end
    compare_outputs();
  endtask

  // Outputs stalled long enough to fill the input buffer
  task automatic output_backpressure();
    flit_t f;
    clear_queues();
    for (int i = 0; i < 5; i++) begin
      f = make_flit(make_coord(2, 1), i == 4, PayloadWidth'($random(seed)));
      tx_q[Eject].push_back(f);
      exp_q[East].push_back(f);
    end
    run_traffic(12);
    if (!ready_dropped) begin
      $display("Input ready never dropped while the outputs were stalled");
      err_count++;
    end
    compare_outputs();
  endtask

  // Watchdog
  initial begin
    while (cycle_count < MaxCycles) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, traffic did not drain", MaxCycles);
    err_count++;
    finish_run();
  end

  initial begin
    rst_i       = 1'b1;
    xy_id_i     = make_coord(1, 1);
    in_flit_i   = '0;
    in_valid_i  = '0;
    out_ready_i = {NumPorts{1'b1}};
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    idle_after_reset();
    xy_all_destinations();
    packet_route_lock();
    two_input_contention();
    output_backpressure();
    finish_run();
  end

endmodule

//--- all.f
+incdir+test
source/noc_pkg.sv
source/flit_fifo.sv
source/route_select.sv
source/output_arbiter.sv
source/mesh_router.sv
test/router_tb.sv
